/* Bender.yml */
package:
  name: fetch_front_end

sources:
  - rtl/fetch_pkg.sv
  - rtl/line_fetcher.sv
  - rtl/instruction_queue.sv
  - rtl/length_decoder.sv
  - rtl/fetch_top.sv
  - target: test
    files:
      - tests/fetch_assertions.sv
      - tests/fetch_tb.sv

/* all.f */
rtl/fetch_pkg.sv
rtl/line_fetcher.sv
rtl/instruction_queue.sv
rtl/length_decoder.sv
rtl/fetch_top.sv
tests/fetch_assertions.sv
tests/fetch_tb.sv

/* rtl/fetch_pkg.sv */
/*
 * Shared widths, typedefs and structs for the instruction fetch front end:
 * fetched line, decoded instruction and the fetcher state encoding
 */
package fetch_pkg;

   // Ring geometry and instruction limits
   localparam int LINE_BYTES     = 16;
   localparam int QUEUE_LINES    = 4;
   localparam int MAX_INST_BYTES = 8;

   // Bits of the byte offset within a line and of the entry index
   localparam int OFFSET_W = $clog2(LINE_BYTES);
   localparam int INDEX_W  = $clog2(QUEUE_LINES);

   typedef logic [15:0] addr_t;

   // Byte k of a line or window sits at bits [8k+7:8k]
   typedef logic [LINE_BYTES*8-1:0] line_t;
   typedef logic [LINE_BYTES*8-1:0] window_t;

   // Valid bytes in the queue, 0 to 64; also the width of the head pointer
   typedef logic [6:0] byte_count_t;

   // Instruction length or bytes consumed, 1 to 8
   typedef logic [3:0] inst_len_t;

   // Line handed from the fetcher to the queue
   typedef struct packed {
      line_t data;
      addr_t addr;
   } fetch_line_t;

   // Decoded instruction, bytes above len are zero
   typedef struct packed {
      addr_t                       pc;
      inst_len_t                   len;
      logic [MAX_INST_BYTES*8-1:0] bytes;
   } instr_t;

   typedef enum logic [1:0] {
      IDLE,
      WAIT_RESP,
      DROP_RESP
   } fetch_state_t;

endpackage

/* rtl/fetch_top.sv */
/*
 * Fetch front end top level: line fetcher, instruction queue
 * and length decoder between the memory port and the decode output
 */
`timescale 1ns/100ps

module fetch_top
   import fetch_pkg::*;
(
   input  logic   clk,
   input  logic   reset_i,
   input  logic   redirect_i,
   input  addr_t  redirect_addr_i,
   output logic   mem_req_o,
   output addr_t  mem_addr_o,
   input  logic   mem_valid_i,
   input  line_t  mem_data_i,
   input  logic   stall_i,
   output logic   instr_valid_o,
   output instr_t instr_o
);

   fetch_line_t fetch_line;
   logic        line_valid;
   logic        line_ready;
   logic        window_valid;
   byte_count_t valid_bytes;
   window_t     window;
   inst_len_t   bytes_read;
   logic        accept;

   line_fetcher u_fetcher (
      .clk             (clk),
      .reset_i         (reset_i),
      .redirect_i      (redirect_i),
      .redirect_addr_i (redirect_addr_i),
      .mem_valid_i     (mem_valid_i),
      .mem_data_i      (mem_data_i),
      .line_ready_i    (line_ready),
      .mem_req_o       (mem_req_o),
      .mem_addr_o      (mem_addr_o),
      .line_valid_o    (line_valid),
      .line_o          (fetch_line)
   );

   // Redirect flushes the ring and loads the target byte offset
   instruction_queue u_queue (
      .clk            (clk),
      .reset_i        (reset_i),
      .flush_i        (redirect_i),
      .load_offset_i  (redirect_addr_i[OFFSET_W-1:0]),
      .line_valid_i   (line_valid),
      .line_i         (fetch_line),
      .bytes_read_i   (bytes_read),
      .accept_i       (accept),
      .line_ready_o   (line_ready),
      .window_valid_o (window_valid),
      .valid_bytes_o  (valid_bytes),
      .window_o       (window)
   );

   length_decoder u_decoder (
      .clk             (clk),
      .reset_i         (reset_i),
      .redirect_i      (redirect_i),
      .redirect_addr_i (redirect_addr_i),
      .stall_i         (stall_i),
      .window_valid_i  (window_valid),
      .valid_bytes_i   (valid_bytes),
      .window_i        (window),
      .bytes_read_o    (bytes_read),
      .accept_o        (accept),
      .instr_valid_o   (instr_valid_o),
      .instr_o         (instr_o)
   );

endmodule

/* rtl/instruction_queue.sv */
/*
 * Instruction queue: four-line ring with a byte-granular head pointer,
 * a 16-byte window starting at the head and a count of valid bytes
 */
`timescale 1ns/100ps

module instruction_queue
   import fetch_pkg::*;
(
   input  logic                clk,
   input  logic                reset_i,
   input  logic                flush_i,
   input  logic [OFFSET_W-1:0] load_offset_i,
   input  logic                line_valid_i,
   input  fetch_line_t         line_i,
   input  inst_len_t           bytes_read_i,
   input  logic                accept_i,
   output logic                line_ready_o,
   output logic                window_valid_o,
   output byte_count_t         valid_bytes_o,
   output window_t             window_o
);

   line_t                  entry_q [QUEUE_LINES];
   logic [QUEUE_LINES-1:0] entry_valid_q;
   logic [QUEUE_LINES-1:0] entry_valid_d;

   // Tail counts lines with one wrap bit, head counts bytes with one wrap bit
   logic [INDEX_W:0]       tail_q;
   byte_count_t            head_q;
   byte_count_t            head_adv;
   byte_count_t            tail_bytes;
   logic                   line_ready_q;

   logic                   in_accept;
   logic                   crossing;
   logic [INDEX_W-1:0]     head_idx;
   logic [INDEX_W-1:0]     next_idx;
   logic [INDEX_W-1:0]     tail_idx;
   logic [2*LINE_BYTES*8-1:0] pair;

   assign in_accept = line_valid_i && line_ready_q;
   assign head_adv  = head_q + byte_count_t'(bytes_read_i);
   assign head_idx  = head_q[OFFSET_W +: INDEX_W];
   assign next_idx  = head_idx + 1'b1;
   assign tail_idx  = tail_q[INDEX_W-1:0];

   // An instruction is at most half a line, so one boundary at most
   assign crossing = accept_i && (head_adv[OFFSET_W +: INDEX_W+1] != head_q[OFFSET_W +: INDEX_W+1]);

   always_comb begin
      entry_valid_d = entry_valid_q;
      if (in_accept) begin
         entry_valid_d[tail_idx] = 1'b1;
      end
      // Head left this entry behind
      if (crossing) begin
         entry_valid_d[head_idx] = 1'b0;
      end
      if (flush_i) begin
         entry_valid_d = '0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         entry_valid_q <= '0;
         tail_q        <= '0;
         head_q        <= '0;
         line_ready_q  <= 1'b0;
      end else begin
         entry_valid_q <= entry_valid_d;
         line_ready_q  <= ~&entry_valid_d;
         if (flush_i) begin
            tail_q <= '0;
            head_q <= byte_count_t'(load_offset_i);
         end else begin
            if (in_accept) tail_q <= tail_q + 1'b1;
            if (accept_i) head_q <= head_adv;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_accept) entry_q[tail_idx] <= line_i.data;
   end

   // Head entry and its successor, shifted down by the head byte offset
   assign pair     = {entry_q[next_idx], entry_q[head_idx]};
   assign window_o = window_t'(pair >> {head_q[OFFSET_W-1:0], 3'b000});

   assign tail_bytes     = byte_count_t'({tail_q, {OFFSET_W{1'b0}}});
   assign window_valid_o = |entry_valid_q;

   // Modulo distance from head to end of the last filled line
   assign valid_bytes_o = window_valid_o ? tail_bytes - head_q : '0;

   assign line_ready_o = line_ready_q;

endmodule

/* rtl/length_decoder.sv */
/*
 * Length decoder: measures the instruction at the window front,
 * emits it registered with its pc and reports the bytes consumed
 */
`timescale 1ns/100ps

module length_decoder
   import fetch_pkg::*;
(
   input  logic        clk,
   input  logic        reset_i,
   input  logic        redirect_i,
   input  addr_t       redirect_addr_i,
   input  logic        stall_i,
   input  logic        window_valid_i,
   input  byte_count_t valid_bytes_i,
   input  window_t     window_i,
   output inst_len_t   bytes_read_o,
   output logic        accept_o,
   output logic        instr_valid_o,
   output instr_t      instr_o
);

   inst_len_t                   len;
   logic [MAX_INST_BYTES*8-1:0] mask;
   addr_t                       pc_q;
   instr_t                      instr_q;
   logic                        instr_valid_q;

   // Length rule is the low three bits of the first byte plus one
   assign len = inst_len_t'(window_i[2:0]) + 1'b1;

   assign accept_o = window_valid_i && (valid_bytes_i >= byte_count_t'(len)) && !stall_i
                     && !redirect_i;
   assign bytes_read_o = len;

   always_comb begin
      for (int k = 0; k < MAX_INST_BYTES; k++) begin
         mask[k*8 +: 8] = (k < len) ? 8'hff : 8'h00;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_i) begin
         pc_q          <= '0;
         instr_valid_q <= 1'b0;
      end else if (redirect_i) begin
         pc_q          <= redirect_addr_i;
         instr_valid_q <= 1'b0;
      end else if (!stall_i) begin
         instr_valid_q <= accept_o;
         if (accept_o) pc_q <= pc_q + addr_t'(len);
      end
   end

   // Output only changes on accept, so it holds while stalled
   always_ff @(posedge clk) begin
      if (accept_o) begin
         instr_q <= '{pc: pc_q, len: len, bytes: window_i[MAX_INST_BYTES*8-1:0] & mask};
      end
   end

   assign instr_valid_o = instr_valid_q;
   assign instr_o       = instr_q;

endmodule

/* rtl/line_fetcher.sv */
/*
 * Line fetcher: issues aligned line requests to instruction memory,
 * holds the answer as a pending line for the queue, drops stale answers
 */
`timescale 1ns/100ps

module line_fetcher
   import fetch_pkg::*;
(
   input  logic        clk,
   input  logic        reset_i,
   input  logic        redirect_i,
   input  addr_t       redirect_addr_i,
   input  logic        mem_valid_i,
   input  line_t       mem_data_i,
   input  logic        line_ready_i,
   output logic        mem_req_o,
   output addr_t       mem_addr_o,
   output logic        line_valid_o,
   output fetch_line_t line_o
);

   fetch_state_t state_q;
   addr_t        next_addr_q;
   addr_t        req_addr_q;
   logic         req_q;
   fetch_line_t  pending_q;
   logic         pending_valid_q;
   logic         issue;
   logic         capture;

   // One request at a time, and only with the pending slot empty
   assign issue   = (state_q == IDLE) && line_ready_i && !pending_valid_q && !redirect_i;
   assign capture = (state_q == WAIT_RESP) && mem_valid_i && !redirect_i;

   assign mem_req_o    = req_q;
   assign mem_addr_o   = req_addr_q;
   assign line_valid_o = pending_valid_q;
   assign line_o       = pending_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         state_q         <= IDLE;
         next_addr_q     <= '0;
         req_q           <= 1'b0;
         pending_valid_q <= 1'b0;
      end else begin
         req_q <= issue;
         case (state_q)
            IDLE:      if (issue) state_q <= WAIT_RESP;
            WAIT_RESP: begin
               if (mem_valid_i) state_q <= IDLE;
               else if (redirect_i) state_q <= DROP_RESP;
            end
            // Answer to a request made before the redirect is swallowed here
            DROP_RESP: if (mem_valid_i) state_q <= IDLE;
            default:   state_q <= IDLE;
         endcase
         if (redirect_i) begin
            next_addr_q     <= redirect_addr_i & ~addr_t'(LINE_BYTES - 1);
            pending_valid_q <= 1'b0;
         end else if (capture) begin
            pending_valid_q <= 1'b1;
         end else if (pending_valid_q && line_ready_i) begin
            pending_valid_q <= 1'b0;
            next_addr_q     <= next_addr_q + addr_t'(LINE_BYTES);
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) req_addr_q <= next_addr_q;
      if (capture) pending_q <= '{data: mem_data_i, addr: req_addr_q};
   end

endmodule

/* tests/fetch_assertions.sv */
/*
 * Concurrent checks bound into fetch_top: memory port rule, quiet reset,
 * instruction length and bytes, pc flow across redirects, hold under stall
 */
`timescale 1ns/100ps

module fetch_assertions
   import fetch_pkg::*;
(
   input logic   clk,
   input logic   reset_i,
   input logic   redirect_i,
   input addr_t  redirect_addr_i,
   input logic   mem_req_i,
   input addr_t  mem_addr_i,
   input logic   mem_valid_i,
   input line_t  mem_data_i,
   input logic   stall_i,
   input logic   instr_valid_i,
   input instr_t instr_i
);

   // Memory contents as they appear on the response port
   logic [7:0] shadow [0:65535];
   addr_t      resp_addr_q;
   logic       outstanding_q;
   logic       stall_q;
   addr_t      exp_pc_q;
   logic       fresh;
   int         fail_count = 0;

   function automatic inst_len_t rule_len(input addr_t pc);
      return inst_len_t'(shadow[pc][2:0]) + 4'd1;
   endfunction

   function automatic logic [63:0] rule_bytes(input addr_t pc, input inst_len_t len);
      logic [63:0] b;
      b = '0;
      for (int k = 0; k < MAX_INST_BYTES; k++) begin
         if (k < len) b[k*8 +: 8] = shadow[pc + addr_t'(k)];
      end
      return b;
   endfunction

   task automatic record_failure(input string msg);
      $error("%s", msg);
      fail_count++;
   endtask

   // A new instruction appears only after an edge without stall
   assign fresh = instr_valid_i && !stall_q;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         outstanding_q <= 1'b0;
         stall_q       <= 1'b0;
         exp_pc_q      <= '0;
      end else begin
         stall_q <= stall_i;
         if (mem_valid_i) outstanding_q <= 1'b0;
         if (mem_req_i) begin
            outstanding_q <= 1'b1;
            resp_addr_q   <= mem_addr_i;
         end
         if (redirect_i) exp_pc_q <= redirect_addr_i;
         else if (fresh) exp_pc_q <= exp_pc_q + addr_t'(rule_len(exp_pc_q));
      end
   end

   always_ff @(posedge clk) begin
      if (mem_valid_i) begin
         for (int k = 0; k < LINE_BYTES; k++) begin
            shadow[resp_addr_q + addr_t'(k)] <= mem_data_i[k*8 +: 8];
         end
      end
   end

   a_reset_quiet: assert property (@(posedge clk) $past(reset_i) |-> !mem_req_i && !instr_valid_i)
      else record_failure("memory request or instruction output active during reset");

   a_line_aligned: assert property (@(posedge clk) disable iff (reset_i)
      mem_req_i |-> mem_addr_i[OFFSET_W-1:0] == '0)
      else record_failure($sformatf("** Error mem_addr_o %h is not line aligned",
                                    $sampled(mem_addr_i)));

   a_one_outstanding: assert property (@(posedge clk) disable iff (reset_i)
      mem_req_i |-> !outstanding_q)
      else record_failure("memory request issued while an answer is outstanding");

   a_len: assert property (@(posedge clk) disable iff (reset_i)
      fresh |-> instr_i.len == rule_len(exp_pc_q))
      else record_failure($sformatf("** Error instr_o.len %h, expected %h",
                                    $sampled(instr_i.len), rule_len($sampled(exp_pc_q))));

   a_bytes: assert property (@(posedge clk) disable iff (reset_i)
      fresh |-> instr_i.bytes == rule_bytes(exp_pc_q, rule_len(exp_pc_q)))
      else record_failure($sformatf("** Error instr_o.bytes %h, expected %h",
                                    $sampled(instr_i.bytes),
                                    rule_bytes($sampled(exp_pc_q),
                                               rule_len($sampled(exp_pc_q)))));

   a_pc_flow: assert property (@(posedge clk) disable iff (reset_i)
      fresh |-> instr_i.pc == exp_pc_q)
      else record_failure($sformatf("** Error instr_o.pc %h, expected %h",
                                    $sampled(instr_i.pc), $sampled(exp_pc_q)));

   a_stall_hold: assert property (@(posedge clk) disable iff (reset_i)
      stall_i && !redirect_i |=> $stable(instr_valid_i) && (!instr_valid_i || $stable(instr_i)))
      else record_failure("instruction output changed while stalled");

endmodule

bind fetch_top fetch_assertions u_checks (
   .clk             (clk),
   .reset_i         (reset_i),
   .redirect_i      (redirect_i),
   .redirect_addr_i (redirect_addr_i),
   .mem_req_i       (mem_req_o),
   .mem_addr_i      (mem_addr_o),
   .mem_valid_i     (mem_valid_i),
   .mem_data_i      (mem_data_i),
   .stall_i         (stall_i),
   .instr_valid_i   (instr_valid_o),
   .instr_i         (instr_o)
);

/* tests/fetch_tb.sv */
/*
 * Testbench for fetch_top: clock, reset, memory model with random latency,
 * redirect and stall stimulus, per-test and closing reports
 */
`timescale 1ns/100ps

module fetch_tb
   import fetch_pkg::*;
();

   logic   clk;
   logic   reset_i;
   logic   redirect_i;
   addr_t  redirect_addr_i;
   logic   mem_req_o;
   addr_t  mem_addr_o;
   logic   mem_valid_i;
   line_t  mem_data_i;
   logic   stall_i;
   logic   instr_valid_o;
   instr_t instr_o;

   logic [7:0]  mem [0:65535];
   logic [31:0] rng;
   logic        stall_seen;
   logic        timed_out;
   int          instr_count = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   fetch_top dut_i (
      .clk             (clk),
      .reset_i         (reset_i),
      .redirect_i      (redirect_i),
      .redirect_addr_i (redirect_addr_i),
      .mem_req_o       (mem_req_o),
      .mem_addr_o      (mem_addr_o),
      .mem_valid_i     (mem_valid_i),
      .mem_data_i      (mem_data_i),
      .stall_i         (stall_i),
      .instr_valid_o   (instr_valid_o),
      .instr_o         (instr_o)
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] xorshift();
      rng = rng ^ (rng << 13);
      rng = rng ^ (rng >> 17);
      rng = rng ^ (rng << 5);
      return rng;
   endfunction

   // Drive point 2 ns after the rising edge
   task automatic step();
      @(posedge clk);
      #2;
   endtask

   task automatic wait_instrs(input int n, input bit random_stall);
      int start;
      int cycles;
      start  = instr_count;
      cycles = 0;
      while (!timed_out && instr_count - start < n) begin
         step();
         if (random_stall) stall_i = (xorshift() % 4 == 0);
         cycles++;
         if (cycles > n * 40 + 200) begin
            $display("Timeout: only %0d of %0d instructions arrived", instr_count - start, n);
            timed_out = 1'b1;
         end
      end
      stall_i = 1'b0;
   endtask

   task automatic wait_request();
      int cycles;
      cycles = 0;
      while (!timed_out && mem_req_o !== 1'b1) begin
         step();
         cycles++;
         if (cycles > 100) begin
            $display("Timeout: no memory request within 100 cycles");
            timed_out = 1'b1;
         end
      end
   endtask

   task automatic report(input string name, input int fails_before);
      int fails;
      fails = dut_i.u_checks.fail_count - fails_before;
      tests_run++;
      if (fails != 0 || timed_out) tests_failed++;
      $display("%s: finished after %0d instructions, %0d assertion failures%s",
               name, instr_count, fails, timed_out ? ", timed out" : "");
   endtask

   // Held instructions under stall are not counted again
   always @(posedge clk) stall_seen <= stall_i;

   always @(negedge clk) begin
      if (!reset_i && instr_valid_o && !stall_seen) instr_count++;
   end

   // Answers each request once, 1 to 4 cycles later
   initial begin : memory_model
      addr_t addr;
      int    lat;
      forever begin
         @(negedge clk);
         if (mem_req_o === 1'b1) begin
            addr = mem_addr_o;
            lat  = 1 + int'(xorshift() % 4);
            repeat (lat) @(posedge clk);
            #2;
            for (int k = 0; k < LINE_BYTES; k++) begin
               mem_data_i[k*8 +: 8] = mem[addr + addr_t'(k)];
            end
            mem_valid_i = 1'b1;
            @(posedge clk);
            #2;
            mem_valid_i = 1'b0;
         end
      end
   end

   initial begin : stimulus
      int fails_before;
      clk             = 1'b0;
      reset_i         = 1'b1;
      redirect_i      = 1'b0;
      redirect_addr_i = '0;
      mem_valid_i     = 1'b0;
      mem_data_i      = '0;
      stall_i         = 1'b0;
      timed_out       = 1'b0;
      rng             = 32'hf851;
      for (int a = 0; a < 65536; a++) begin
         mem[a] = 8'(xorshift());
      end
      repeat (4) @(posedge clk);
      #2;
      reset_i = 1'b0;

      fails_before = dut_i.u_checks.fail_count;
      wait_instrs(300, 1'b0);
      report("reset and sequential flow", fails_before);

      fails_before = dut_i.u_checks.fail_count;
      for (int i = 0; i < 24; i++) begin
         // Odd rounds redirect while a line request is in flight
         if (i % 2 == 1) begin
            wait_request();
         end else begin
            repeat (xorshift() % 12) step();
         end
         redirect_i      = 1'b1;
         redirect_addr_i = addr_t'(xorshift());
         step();
         redirect_i = 1'b0;
         wait_instrs(6, 1'b0);
      end
      report("redirect", fails_before);

      fails_before = dut_i.u_checks.fail_count;
      for (int i = 0; i < 6; i++) begin
         wait_instrs(10, 1'b1);
         stall_i = 1'b1;
         repeat (30) step();
         stall_i = 1'b0;
      end
      wait_instrs(40, 1'b1);
      report("stall", fails_before);

      $display("%0d tests run, %0d failed, %0d assertion failures, %0d instructions",
               tests_run, tests_failed, dut_i.u_checks.fail_count, instr_count);
      if (!timed_out && tests_failed == 0 && dut_i.u_checks.fail_count == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule
